/* rename_params.svh */
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// micro-ops renamed together each cycle
`define RN_WIDTH       2

`define NUM_ARCH_REGS  32
`define NUM_PHYS_REGS  64
`define ROB_DEPTH      16

`define DATA_W         64
`define IMM_W          16
`define PC_W           32

// zero register, never renamed
`define XZR_REG        (`NUM_ARCH_REGS - 1)
// table slot after the gprs holds the flags
`define NZCV_SLOT      `NUM_ARCH_REGS

`endif

/* rename_pkg.sv */
`include "rename_params.svh"

package rename_pkg;

  typedef logic [$clog2(`NUM_PHYS_REGS)-1:0] phys_tag_t;
  typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] arch_reg_t;
  typedef logic [`DATA_W-1:0]                reg_data_t;
  typedef logic [`PC_W-1:0]                  pc_t;
  typedef logic [`IMM_W-1:0]                 imm_t;

  // tags popped per cycle, 0 up to 3 per lane
  typedef logic [$clog2(3 * `RN_WIDTH + 1)-1:0] take_cnt_t;

  typedef enum logic [3:0] {
    UOP_ADD   = 4'h0,
    UOP_SUB   = 4'h1,
    UOP_AND   = 4'h2,
    UOP_BL    = 4'h3,
    UOP_BCOND = 4'h4,
    UOP_HLT   = 4'h5
  } uopcode_e;

  typedef struct packed {
    uopcode_e  uopcode;
    logic      valb_sel;       // 1 = reg-reg, 0 = reg-imm
    arch_reg_t dst;
    arch_reg_t src1;
    arch_reg_t src2;
    imm_t      imm;
    logic      set_nzcv;
    pc_t       pc;
    logic      predict_taken;
    pc_t       branch_target;
  } uop_t;

  typedef struct packed {
    uop_t      uop;
    pc_t       next_pc;
    phys_tag_t src1_phys;
    phys_tag_t src2_phys;      // immediate tag for reg-imm uops
    phys_tag_t dst_phys;
    phys_tag_t prev_dst_phys;  // freed when this entry retires
    phys_tag_t nzcv_phys;
    phys_tag_t prev_nzcv_phys;
    logic      dst_alloc;
    logic      nzcv_alloc;
  } rob_entry_t;

endpackage

/* tag_if.sv */
`include "rename_params.svh"

interface tag_if import rename_pkg::*; ();

  // free list side, oldest free tag in slot 0
  phys_tag_t [3*`RN_WIDTH-1:0] heads;
  logic                        avail;    // a full group's worth of tags is free

  take_cnt_t                   take_count;

  // released tags, slot 0 pushed first
  logic [1:0]                  rel_en;
  phys_tag_t [1:0]             rel_tag;

  modport alloc (
    output heads, avail,
    input  take_count, rel_en, rel_tag
  );

  modport renamer (input heads, avail, output take_count);

  modport retirer (output rel_en, rel_tag);

endinterface

/* free_list.sv */
`include "rename_params.svh"

module free_list import rename_pkg::*; (
  input logic  clk,
  input logic  rst_N_in,
  tag_if.alloc tags
);

  localparam int PTR_W = $clog2(`NUM_PHYS_REGS);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W:0]   cnt_t;

  // tags above the identity map plus the flags tag
  localparam int   FREE_AT_RESET = `NUM_PHYS_REGS - `NUM_ARCH_REGS - 1;
  localparam cnt_t MIN_FREE      = cnt_t'(3 * `RN_WIDTH);

  phys_tag_t fifo [`NUM_PHYS_REGS];
  ptr_t      head;
  ptr_t      tail;
  cnt_t      count;
  logic [1:0] push_n;

  assign push_n     = 2'(tags.rel_en[0]) + 2'(tags.rel_en[1]);
  assign tags.avail = count >= MIN_FREE;

  // peek window, wraps with the pointer
  always_comb begin
    for (int k = 0; k < 3 * `RN_WIDTH; k++) begin
      tags.heads[k] = fifo[head + ptr_t'(k)];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      for (int i = 0; i < `NUM_PHYS_REGS; i++) begin
        fifo[i] <= phys_tag_t'(i + `NUM_ARCH_REGS + 1);  // 33, 34, ...
      end
      head  <= '0;
      tail  <= ptr_t'(FREE_AT_RESET);
      count <= cnt_t'(FREE_AT_RESET);
    end else begin
      head <= head + ptr_t'(tags.take_count);

      // compact append, slot 1 lands right after slot 0 if both
      if (tags.rel_en[0]) begin
        fifo[tail] <= tags.rel_tag[0];
      end
      if (tags.rel_en[1]) begin
        fifo[tail + ptr_t'(tags.rel_en[0])] <= tags.rel_tag[1];
      end
      tail  <= tail + ptr_t'(push_n);
      count <= count - cnt_t'(tags.take_count) + cnt_t'(push_n);
    end
  end

  // renamer must never pull more than is actually free
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_N_in)
    cnt_t'(tags.take_count) <= count);

  // releases never outrun allocations
  a_count_bound: assert property (@(posedge clk) disable iff (!rst_N_in)
    count <= cnt_t'(`NUM_PHYS_REGS));

endmodule

/* rat.sv */
`include "rename_params.svh"

module rat import rename_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_N_in,

  input  logic                        in_valid,
  input  uop_t       [`RN_WIDTH-1:0]  in_uops,
  output logic                        in_accept,

  tag_if.renamer                      tags,

  output rob_entry_t [`RN_WIDTH-1:0]  rob_data,
  output logic                        rob_valid,
  input  logic                        rob_ready,

  output logic       [`RN_WIDTH-1:0]  wr_en,
  output phys_tag_t  [`RN_WIDTH-1:0]  wr_tag,
  output reg_data_t  [`RN_WIDTH-1:0]  wr_data
);

  phys_tag_t  [`NUM_ARCH_REGS:0] map_q;  // last slot is nzcv
  phys_tag_t  [`NUM_ARCH_REGS:0] map_d;
  rob_entry_t [`RN_WIDTH-1:0]    ent_d;
  logic       [`RN_WIDTH-1:0]    imm_en_d;
  phys_tag_t  [`RN_WIDTH-1:0]    imm_tag_d;
  reg_data_t  [`RN_WIDTH-1:0]    imm_data_d;
  take_cnt_t                     used;
  logic                          fire;

  assign fire            = in_valid && tags.avail && rob_ready;
  assign in_accept       = fire;
  assign tags.take_count = fire ? used : '0;

  // lanes renamed in order, map_d carries earlier lanes' updates forward
  always_comb begin
    uop_t u;
    logic need_dst;
    logic need_imm;
    logic taken_br;

    map_d = map_q;
    used  = '0;
    for (int l = 0; l < `RN_WIDTH; l++) begin
      u        = in_uops[l];
      need_dst = (u.dst != arch_reg_t'(`XZR_REG)) && (u.uopcode != UOP_HLT);
      need_imm = !u.valb_sel && (u.uopcode != UOP_HLT);
      taken_br = (u.uopcode == UOP_BL || u.uopcode == UOP_BCOND) && u.predict_taken;

      ent_d[l]           = '0;
      ent_d[l].uop       = u;
      ent_d[l].next_pc   = taken_br ? u.branch_target : u.pc + pc_t'(4);
      ent_d[l].src1_phys = map_d[u.src1];
      ent_d[l].src2_phys = map_d[u.src2];

      // without a new tag dst keeps its current mapping
      ent_d[l].prev_dst_phys = map_d[u.dst];
      ent_d[l].dst_phys      = map_d[u.dst];
      if (need_dst) begin
        ent_d[l].dst_phys = tags.heads[used];
        used              = used + take_cnt_t'(1);
      end

      imm_en_d[l]   = need_imm;
      imm_tag_d[l]  = '0;
      imm_data_d[l] = reg_data_t'(u.imm);  // zero extend
      if (need_imm) begin
        imm_tag_d[l]       = tags.heads[used];
        ent_d[l].src2_phys = tags.heads[used];
        used               = used + take_cnt_t'(1);
      end

      ent_d[l].prev_nzcv_phys = map_d[`NZCV_SLOT];
      ent_d[l].nzcv_phys      = map_d[`NZCV_SLOT];
      if (u.set_nzcv) begin
        ent_d[l].nzcv_phys = tags.heads[used];
        used               = used + take_cnt_t'(1);
      end

      ent_d[l].dst_alloc  = need_dst;
      ent_d[l].nzcv_alloc = u.set_nzcv;

      // visible to later lanes of this group
      if (need_dst) begin
        map_d[u.dst] = ent_d[l].dst_phys;
      end
      if (u.set_nzcv) begin
        map_d[`NZCV_SLOT] = ent_d[l].nzcv_phys;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      // identity map, flags land on tag 32
      for (int i = 0; i <= `NUM_ARCH_REGS; i++) begin
        map_q[i] <= phys_tag_t'(i);
      end
      rob_valid <= 1'b0;
      wr_en     <= '0;
    end else begin
      rob_valid <= fire;
      wr_en     <= fire ? imm_en_d : '0;
      if (fire) begin
        map_q <= map_d;
      end
    end
  end

  // group payload, qualified by rob_valid / wr_en
  always_ff @(posedge clk) begin
    if (fire) begin
      rob_data <= ent_d;
      wr_tag   <= imm_tag_d;
      wr_data  <= imm_data_d;
    end
  end

  a_take_bound: assert property (@(posedge clk) disable iff (!rst_N_in)
    tags.take_count <= take_cnt_t'(3 * `RN_WIDTH));

  // every group sent to the rob was renamed while the free list had room
  a_fire_had_tags: assert property (@(posedge clk) disable iff (!rst_N_in)
    rob_valid |-> $past(tags.avail));

endmodule

/* phys_regfile.sv */
`include "rename_params.svh"

module phys_regfile import rename_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_N_in,
  input  logic      [`RN_WIDTH-1:0]  wr_en,
  input  phys_tag_t [`RN_WIDTH-1:0]  wr_tag,
  input  reg_data_t [`RN_WIDTH-1:0]  wr_data,
  input  phys_tag_t                  rd_tag,
  output reg_data_t                  rd_data
);

  reg_data_t regs [`NUM_PHYS_REGS];

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      for (int i = 0; i < `NUM_PHYS_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int l = 0; l < `RN_WIDTH; l++) begin
        if (wr_en[l]) begin
          regs[wr_tag[l]] <= wr_data[l];
        end
      end
    end
  end

  assign rd_data = regs[rd_tag];  // async read

  // xzr stays zero only as long as the renamer never hands out tag 31
  for (genvar l = 0; l < `RN_WIDTH; l++) begin : g_xzr_chk
    a_no_xzr_write: assert property (@(posedge clk) disable iff (!rst_N_in)
      wr_en[l] |-> wr_tag[l] != phys_tag_t'(`XZR_REG));
  end

endmodule

/* rob.sv */
`include "rename_params.svh"

module rob import rename_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_N_in,

  input  rob_entry_t [`RN_WIDTH-1:0]  rob_data,
  input  logic                        rob_valid,
  output logic                        rob_ready,

  input  logic                        commit,
  output logic                        retire_valid,
  output rob_entry_t                  retire_entry,

  tag_if.retirer                      tags
);

  localparam int PTR_W = $clog2(`ROB_DEPTH);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W:0]   cnt_t;

  localparam cnt_t DEPTH       = cnt_t'(`ROB_DEPTH);
  localparam cnt_t GROUP_SLOTS = cnt_t'(`RN_WIDTH);
  // one group may already be in flight from the rat
  localparam cnt_t READY_SLOTS = cnt_t'(2 * `RN_WIDTH);

  rob_entry_t q [`ROB_DEPTH];
  ptr_t       head;
  ptr_t       tail;
  cnt_t       count;
  cnt_t       free_slots;
  logic       do_retire;

  assign free_slots   = DEPTH - count;
  assign rob_ready    = free_slots >= READY_SLOTS;
  assign do_retire    = commit && (count != '0);
  assign retire_valid = do_retire;
  assign retire_entry = q[head];

  // superseded mappings go back to the free list
  assign tags.rel_en[0]  = do_retire && retire_entry.dst_alloc;
  assign tags.rel_tag[0] = retire_entry.prev_dst_phys;
  assign tags.rel_en[1]  = do_retire && retire_entry.nzcv_alloc;
  assign tags.rel_tag[1] = retire_entry.prev_nzcv_phys;

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (rob_valid) begin
        tail <= tail + ptr_t'(`RN_WIDTH);
      end
      if (do_retire) begin
        head <= head + ptr_t'(1);
      end
      count <= count + (rob_valid ? GROUP_SLOTS : '0) - cnt_t'(do_retire);
    end
  end

  always_ff @(posedge clk) begin
    if (rob_valid) begin
      for (int k = 0; k < `RN_WIDTH; k++) begin
        q[tail + ptr_t'(k)] <= rob_data[k];  // whole group at once
      end
    end
  end

  // rat must honour rob_ready with one group of slack
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_N_in)
    rob_valid |-> free_slots >= GROUP_SLOTS);

endmodule

/* rename_top.sv */
`include "rename_params.svh"

module rename_top import rename_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_N_in,

  input  logic                        in_valid,
  input  uop_t       [`RN_WIDTH-1:0]  in_uops,
  output logic                        in_accept,

  output logic                        out_valid,
  output rob_entry_t [`RN_WIDTH-1:0]  out_entries,

  input  logic                        commit,
  output logic                        retire_valid,
  output rob_entry_t                  retire_entry,

  input  phys_tag_t                   rd_tag,
  output reg_data_t                   rd_data
);

  tag_if tag_bus ();

  rob_entry_t [`RN_WIDTH-1:0] rob_data;
  logic                       rob_valid;
  logic                       rob_ready;
  logic       [`RN_WIDTH-1:0] wr_en;
  phys_tag_t  [`RN_WIDTH-1:0] wr_tag;
  reg_data_t  [`RN_WIDTH-1:0] wr_data;

  // observation of what enters the rob
  assign out_valid   = rob_valid;
  assign out_entries = rob_data;

  rat u_rat (
    .clk       (clk),
    .rst_N_in  (rst_N_in),
    .in_valid  (in_valid),
    .in_uops   (in_uops),
    .in_accept (in_accept),
    .tags      (tag_bus.renamer),
    .rob_data  (rob_data),
    .rob_valid (rob_valid),
    .rob_ready (rob_ready),
    .wr_en     (wr_en),
    .wr_tag    (wr_tag),
    .wr_data   (wr_data)
  );

  free_list u_free_list (
    .clk      (clk),
    .rst_N_in (rst_N_in),
    .tags     (tag_bus.alloc)
  );

  phys_regfile u_prf (
    .clk      (clk),
    .rst_N_in (rst_N_in),
    .wr_en    (wr_en),
    .wr_tag   (wr_tag),
    .wr_data  (wr_data),
    .rd_tag   (rd_tag),
    .rd_data  (rd_data)
  );

  rob u_rob (
    .clk          (clk),
    .rst_N_in     (rst_N_in),
    .rob_data     (rob_data),
    .rob_valid    (rob_valid),
    .rob_ready    (rob_ready),
    .commit       (commit),
    .retire_valid (retire_valid),
    .retire_entry (retire_entry),
    .tags         (tag_bus.retirer)
  );

endmodule

/* tb_clock.sv */
module tb_clock #(
  parameter int PERIOD = 8
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

/* tb_rename.sv */
`include "rename_params.svh"

module tb_rename import rename_pkg::*; ();

  typedef uop_t       [`RN_WIDTH-1:0] uops_t;
  typedef rob_entry_t [`RN_WIDTH-1:0] group_t;

  logic        clk;
  logic        rst_N_in;
  logic        in_valid;
  uops_t       in_uops;
  logic        in_accept;
  logic        out_valid;
  group_t      out_entries;
  logic        commit;
  logic        retire_valid;
  rob_entry_t  retire_entry;
  phys_tag_t   rd_tag;
  reg_data_t   rd_data;

  phys_tag_t   model_map [0:`NUM_ARCH_REGS];  // last slot is nzcv
  phys_tag_t   model_free [$];
  group_t      exp_out_q [$];                 // accepted, not yet seen on out_valid
  rob_entry_t  rob_q [$];                     // what the rob should hold
  phys_tag_t   imm_tags [$];
  reg_data_t   imm_vals [$];

  logic [31:0] lcg_state;
  logic [31:0] r;
  pc_t         pc_cnt;
  int          errors;
  int          err_mark;
  int          tests;
  int          acc;
  int          exp_groups;
  uops_t       grp_in;

  tb_clock clk_gen (.clk(clk));

  rename_top dut (.*);

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic uop_t mk_uop(uopcode_e op, logic vs, int d, int s1, int s2,
                                  int imm, logic nz);
    uop_t u;
    u          = '0;
    u.uopcode  = op;
    u.valb_sel = vs;
    u.dst      = arch_reg_t'(d);
    u.src1     = arch_reg_t'(s1);
    u.src2     = arch_reg_t'(s2);
    u.imm      = imm_t'(imm);
    u.set_nzcv = nz;
    u.pc       = pc_cnt;
    pc_cnt     = pc_cnt + pc_t'(4);
    return u;
  endfunction

  // expected entries for one accepted group, lanes in order
  function automatic void model_rename(input uops_t g);
    group_t     grp;
    rob_entry_t e;
    uop_t       u;
    for (int l = 0; l < `RN_WIDTH; l++) begin
      u = g[l];
      e = '0;
      e.uop = u;
      e.next_pc = ((u.uopcode == UOP_BL || u.uopcode == UOP_BCOND) && u.predict_taken) ?
                  u.branch_target : u.pc + pc_t'(4);
      e.src1_phys     = model_map[int'(u.src1)];
      e.src2_phys     = model_map[int'(u.src2)];
      e.prev_dst_phys = model_map[int'(u.dst)];
      e.dst_phys      = e.prev_dst_phys;
      e.dst_alloc     = int'(u.dst) != `XZR_REG && u.uopcode != UOP_HLT;
      if (e.dst_alloc) e.dst_phys = model_free.pop_front();
      if (!u.valb_sel && u.uopcode != UOP_HLT) begin
        e.src2_phys = model_free.pop_front();  // immediate gets its own tag
        imm_tags.push_back(e.src2_phys);
        imm_vals.push_back(reg_data_t'(u.imm));
      end
      e.prev_nzcv_phys = model_map[`NZCV_SLOT];
      e.nzcv_phys      = e.prev_nzcv_phys;
      e.nzcv_alloc     = u.set_nzcv;
      if (u.set_nzcv) e.nzcv_phys = model_free.pop_front();
      if (e.dst_alloc) model_map[int'(u.dst)] = e.dst_phys;
      if (u.set_nzcv) model_map[`NZCV_SLOT] = e.nzcv_phys;
      grp[l] = e;
    end
    exp_out_q.push_back(grp);
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("mismatch t=%0t %s got %b exp %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // outputs are stable mid-cycle
  always @(negedge clk) begin
    group_t     grp;
    rob_entry_t e;
    logic       exp_acc;
    logic       exp_ret;
    if (rst_N_in) begin
      exp_acc = in_valid && model_free.size() >= 3 * `RN_WIDTH &&
                (`ROB_DEPTH - rob_q.size()) >= 2 * `RN_WIDTH;
      exp_ret = commit && rob_q.size() != 0;
      check_bit("in_accept", in_accept, exp_acc);
      check_bit("retire_valid", retire_valid, exp_ret);
      if (retire_valid && exp_ret) begin
        e = rob_q.pop_front();
        assert (retire_entry === e) else begin
          $display("mismatch t=%0t retire_entry got %h exp %h", $time, retire_entry, e);
          errors++;
        end
        if (e.dst_alloc) model_free.push_back(e.prev_dst_phys);
        if (e.nzcv_alloc) model_free.push_back(e.prev_nzcv_phys);
      end
      check_bit("out_valid", out_valid, exp_out_q.size() != 0);
      if (out_valid && exp_out_q.size() != 0) begin
        grp = exp_out_q.pop_front();
        for (int l = 0; l < `RN_WIDTH; l++) begin
          assert (out_entries[l] === grp[l]) else begin
            $display("mismatch t=%0t out_entries[%0d] got %h exp %h",
                     $time, l, out_entries[l], grp[l]);
            errors++;
          end
          rob_q.push_back(grp[l]);
        end
      end
      if (in_accept && exp_acc) model_rename(in_uops);
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic send_group(input uops_t g);
    int   waited;
    logic got;
    waited   = 0;
    got      = 1'b0;
    in_valid = 1'b1;
    in_uops  = g;
    while (!got && waited < 50) begin
      @(negedge clk);
      got = in_accept;
      next_cycle();
      waited++;
    end
    in_valid = 1'b0;
    if (!got) begin
      $display("timeout at t=%0t, group was never accepted", $time);
      errors++;
    end
  endtask

  // drives one group for a fixed window, counting accepts
  task automatic hold_group(input uops_t g, input int cycles, output int accepts);
    accepts  = 0;
    in_valid = 1'b1;
    in_uops  = g;
    repeat (cycles) begin
      @(negedge clk);
      if (in_accept) accepts++;
      next_cycle();
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (exp_out_q.size() != 0 && waited < 20) begin
      next_cycle();
      waited++;
    end
    if (exp_out_q.size() != 0) begin
      $display("timeout at t=%0t, accepted group never reached the rob", $time);
      errors++;
    end
  endtask

  // immediates and xzr through the read port
  task automatic check_imms();
    while (imm_tags.size() != 0) begin
      rd_tag = imm_tags.pop_front();
      @(negedge clk);
      assert (rd_data === imm_vals[0]) else begin
        $display("mismatch t=%0t rd_data[%0d] got %h exp %h", $time, rd_tag, rd_data,
                 imm_vals[0]);
        errors++;
      end
      void'(imm_vals.pop_front());
      next_cycle();
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    commit = 1'b1;
    while ((rob_q.size() != 0 || exp_out_q.size() != 0) && waited < 64) begin
      next_cycle();
      waited++;
    end
    commit = 1'b0;
    if (rob_q.size() != 0) begin
      $display("timeout at t=%0t, rob did not drain", $time);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    wait_idle();
    check_imms();
    drain();
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
    err_mark = errors;
  endtask

  initial begin
    rst_N_in  = 1'b0;
    in_valid  = 1'b0;
    in_uops   = '0;
    commit    = 1'b0;
    rd_tag    = '0;
    lcg_state = 32'd99;
    pc_cnt    = pc_t'(32'h1000);
    errors    = 0;
    err_mark  = 0;
    tests     = 0;
    for (int i = 0; i <= `NUM_ARCH_REGS; i++) model_map[i] = phys_tag_t'(i);
    for (int i = `NUM_ARCH_REGS + 1; i < `NUM_PHYS_REGS; i++) model_free.push_back(phys_tag_t'(i));
    repeat (4) @(posedge clk);
    #1;
    rst_N_in = 1'b1;

    grp_in[0] = mk_uop(UOP_ADD, 1'b1, 1, 2, 3, 0, 1'b0);
    grp_in[1] = mk_uop(UOP_SUB, 1'b1, 4, 5, 6, 0, 1'b0);
    send_group(grp_in);
    grp_in[0] = mk_uop(UOP_AND, 1'b1, 20, 21, 22, 0, 1'b0);
    grp_in[1] = mk_uop(UOP_ADD, 1'b1, 23, 24, 25, 0, 1'b0);
    send_group(grp_in);
    finish_test("identity mapping");

    grp_in[0] = mk_uop(UOP_ADD, 1'b1, 7, 1, 2, 0, 1'b1);
    grp_in[1] = mk_uop(UOP_SUB, 1'b1, 8, 7, 7, 0, 1'b1);  // reads lane 0 dst
    send_group(grp_in);
    finish_test("intra-group bypass");

    grp_in[0] = mk_uop(UOP_ADD, 1'b0, 9, 1, 0, 'hbeef, 1'b0);
    grp_in[1] = mk_uop(UOP_AND, 1'b0, 10, 9, 0, 'h1234, 1'b1);
    send_group(grp_in);
    finish_test("immediates");

    grp_in[0] = mk_uop(UOP_ADD, 1'b1, 31, 31, 31, 0, 1'b0);
    grp_in[1] = mk_uop(UOP_HLT, 1'b0, 5, 31, 3, 0, 1'b0);  // imm form, still no tag
    send_group(grp_in);
    imm_tags.push_back(phys_tag_t'(`XZR_REG));
    imm_vals.push_back('0);
    finish_test("xzr and hlt");

    for (int g = 0; g < 6; g++) begin
      for (int l = 0; l < `RN_WIDTH; l++) begin
        r = lcg_next();
        grp_in[l] = mk_uop(r[20] ? UOP_BL : UOP_BCOND, 1'b1, int'(r[28:24]),
                           int'(r[14:10]), int'(r[9:5]), 0, 1'b0);
        grp_in[l].predict_taken = r[21];
        grp_in[l].branch_target = lcg_next() & 32'hffff_fffc;
      end
      send_group(grp_in);
    end
    finish_test("next pc");

    // six tags per group and avail needs six, so the free list sets the limit
    exp_groups = model_free.size() / (3 * `RN_WIDTH);
    grp_in[0] = mk_uop(UOP_ADD, 1'b0, 11, 1, 0, 'h00a5, 1'b1);
    grp_in[1] = mk_uop(UOP_SUB, 1'b0, 12, 11, 0, 'h5a00, 1'b1);
    hold_group(grp_in, 12, acc);
    assert (acc == exp_groups) else begin
      $display("mismatch t=%0t accepted_groups got %0d exp %0d", $time, acc, exp_groups);
      errors++;
    end
    wait_idle();
    check_imms();
    drain();
    // 16 rob slots, two per group
    grp_in[0] = mk_uop(UOP_SUB, 1'b1, 13, 13, 2, 0, 1'b0);
    grp_in[1] = mk_uop(UOP_ADD, 1'b1, 14, 13, 3, 0, 1'b0);
    hold_group(grp_in, 14, acc);
    assert (acc == 8) else begin
      $display("mismatch t=%0t accepted_groups got %0d exp %0d", $time, acc, 8);
      errors++;
    end
    wait_idle();
    drain();
    send_group(grp_in);  // reuses tags in release order
    send_group(grp_in);
    finish_test("back-pressure and reuse");

    $display("tests=%0d errors=%0d", tests, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+.
rename_pkg.sv
tag_if.sv
free_list.sv
rat.sv
phys_regfile.sv
rob.sv
rename_top.sv
tb_clock.sv
tb_rename.sv

/* run.sh */
#!/bin/sh
# build and run the rename stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_rename -Mdir obj_dir -o sim_rename
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_rename)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q '^>>> PASS$'; then
  exit 0
fi
echo "pass message not found"
exit 1
